// ==== pio_consts.svh ====
// Widths, opcodes, operand codes and MOV operations of the state machine
`ifndef PIO_CONSTS_SVH
`define PIO_CONSTS_SVH

`define PIO_WORD_W   32
`define PIO_ADDR_W   5
`define PIO_COUNT_W  6          // Holds 0 to 32

`define OP_JMP       3'd0
`define OP_WAIT      3'd1
`define OP_IN        3'd2
`define OP_OUT       3'd3
`define OP_PUSHPULL  3'd4
`define OP_MOV       3'd5
`define OP_SET       3'd7

`define SRC_PINS     3'd0
`define SRC_X        3'd1
`define SRC_Y        3'd2
`define SRC_NULL     3'd3
`define SRC_ISR      3'd6
`define SRC_OSR      3'd7

`define DST_PINS     3'd0
`define DST_X        3'd1
`define DST_Y        3'd2
`define DST_PINDIRS  3'd4
`define DST_PC       3'd5
`define DST_ISR      3'd6
`define DST_OSR      3'd7

`define MOV_NONE     2'd0
`define MOV_INVERT   2'd1
`define MOV_REVERSE  2'd2

`endif

// ==== pio_pkg.sv ====
// Instruction word type with its generic and MOV decodings
package pio_pkg;

  // Same 16 bits, two field layouts
  typedef union packed {
    struct packed {
      logic [2:0] op;
      logic [4:0] delay;
      logic [2:0] op1;          // Condition, source, destination or flags
      logic [4:0] op2;          // Address, bit count, index or data
    } gen;
    struct packed {
      logic [2:0] op;
      logic [4:0] delay;
      logic [2:0] dest;
      logic [1:0] mov_op;       // None, invert or reverse
      logic [2:0] mov_src;
    } mov;
  } instr_t;

endpackage

// ==== sm_bus_if.sv ====
// Register write bus from the execute unit and status back from the registers
`include "pio_consts.svh"

interface sm_bus_if;

  logic [`PIO_WORD_W-1:0]  new_val;
  logic [4:0]              shift_n;      // 0 means 32
  logic                    wr_x, wr_y, dec_x, dec_y;
  logic                    wr_isr, shift_isr, wr_osr, shift_osr;
  logic                    wr_pc, advance;
  logic                    wr_out_pins, wr_out_dirs, wr_set_pins, wr_set_dirs;

  logic [`PIO_WORD_W-1:0]  x, y;
  logic [`PIO_WORD_W-1:0]  isr, osr;
  logic [`PIO_COUNT_W-1:0] isr_count, osr_count;
  logic [`PIO_WORD_W-1:0]  out_data;     // Bits leaving the OSR, right-aligned

  modport exec (
    output new_val, shift_n, wr_x, wr_y, dec_x, dec_y, wr_isr, shift_isr,
           wr_osr, shift_osr, wr_pc, advance, wr_out_pins, wr_out_dirs,
           wr_set_pins, wr_set_dirs,
    input  x, y, isr, isr_count, osr, osr_count, out_data
  );

  modport scratch   (input new_val, wr_x, wr_y, dec_x, dec_y, output x, y);
  modport shift_in  (input new_val, shift_n, wr_isr, shift_isr, output isr, isr_count);
  modport shift_out (input new_val, shift_n, wr_osr, shift_osr,
                     output osr, osr_count, out_data);
  modport pc        (input new_val, wr_pc, advance);
  modport pins      (input new_val, wr_out_pins, wr_out_dirs, wr_set_pins, wr_set_dirs);

endinterface

// ==== sm_exec.sv ====
// Execute unit: decode, write strobes, jump and wait conditions, delay counter
`include "pio_consts.svh"

module sm_exec import pio_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   en,
  input  logic [15:0]            instr,
  input  logic [`PIO_WORD_W-1:0] input_pins,
  input  logic                   empty,
  input  logic                   full,
  input  logic                   jmp_pin,
  input  logic [4:0]             pins_in_base,
  input  logic [4:0]             osr_threshold,
  input  logic [`PIO_WORD_W-1:0] din,
  output logic                   push,
  output logic                   pull,
  output logic [`PIO_WORD_W-1:0] dout,
  sm_bus_if.exec                 bus
);

  instr_t                    iw;
  logic [4:0]                delay_cnt;
  logic                      waiting, fire, jmp_take, any_strobe;
  logic [4:0]                rel_pin;
  logic [2:0]                src_sel;
  logic [2*`PIO_WORD_W-1:0]  pins_dbl;
  logic [`PIO_WORD_W-1:0]    in_pins, src_val, mov_val, op2_ext;

  function automatic logic [`PIO_WORD_W-1:0] bit_op(input logic [`PIO_WORD_W-1:0] v,
                                                    input logic [1:0] op);
    logic [`PIO_WORD_W-1:0] r;
    r = v;
    if (op == `MOV_INVERT) r = ~v;
    else if (op == `MOV_REVERSE) begin
      for (int i = 0; i < `PIO_WORD_W; i++) begin
        r[i] = v[`PIO_WORD_W-1-i];
      end
    end
    return r;
  endfunction

  assign iw       = instr;
  assign pins_dbl = {input_pins, input_pins} >> pins_in_base;
  assign in_pins  = pins_dbl[`PIO_WORD_W-1:0];      // Pin in_base lands at bit 0
  assign rel_pin  = pins_in_base + iw.gen.op2;
  assign op2_ext  = {{(`PIO_WORD_W-5){1'b0}}, iw.gen.op2};
  assign src_sel  = (iw.gen.op == `OP_MOV) ? iw.mov.mov_src : iw.gen.op1;
  assign mov_val  = bit_op(src_val, iw.mov.mov_op);
  assign fire     = en && (delay_cnt == '0) && !waiting;
  assign bus.shift_n = iw.gen.op2;
  assign bus.advance = fire && !bus.wr_pc;
  assign dout     = push ? bus.isr : '0;

  always_comb begin
    case (src_sel)
      `SRC_PINS: src_val = in_pins;
      `SRC_X:    src_val = bus.x;
      `SRC_Y:    src_val = bus.y;
      `SRC_ISR:  src_val = bus.isr;
      `SRC_OSR:  src_val = bus.osr;
      default:   src_val = '0;                      // NULL and reserved
    endcase
  end

  always_comb begin
    case (iw.gen.op1)
      3'd0:    jmp_take = 1'b1;
      3'd1:    jmp_take = (bus.x == '0);
      3'd2:    jmp_take = (bus.x != '0);             // X--
      3'd3:    jmp_take = (bus.y == '0);
      3'd4:    jmp_take = (bus.y != '0);             // Y--
      3'd5:    jmp_take = (bus.x != bus.y);
      3'd6:    jmp_take = jmp_pin;
      default: jmp_take = (bus.osr_count < {1'b0, osr_threshold}); // !OSRE
    endcase
  end

  // Stall conditions, independent of fire
  always_comb begin
    waiting = 1'b0;
    if (iw.gen.op == `OP_WAIT) begin
      if (iw.gen.op1[1:0] == 2'd0) waiting = (input_pins[iw.gen.op2] != iw.gen.op1[2]);
      else if (iw.gen.op1[1:0] == 2'd1) waiting = (input_pins[rel_pin] != iw.gen.op1[2]);
    end else if (iw.gen.op == `OP_PUSHPULL) begin
      waiting = iw.gen.op1[0] && (iw.gen.op1[2] ? empty : full);
    end
  end

  always_comb begin
    bus.new_val = '0;
    {bus.wr_x, bus.wr_y, bus.dec_x, bus.dec_y} = '0;
    {bus.wr_isr, bus.shift_isr, bus.wr_osr, bus.shift_osr, bus.wr_pc} = '0;
    {bus.wr_out_pins, bus.wr_out_dirs, bus.wr_set_pins, bus.wr_set_dirs} = '0;
    push = 1'b0;
    pull = 1'b0;
    if (fire) begin
      case (iw.gen.op)
        `OP_JMP: begin
          bus.new_val = op2_ext;
          bus.wr_pc   = jmp_take;
          bus.dec_x   = (iw.gen.op1 == 3'd2) && (bus.x != '0);
          bus.dec_y   = (iw.gen.op1 == 3'd4) && (bus.y != '0);
        end
        `OP_IN: begin
          bus.new_val   = src_val;
          bus.shift_isr = (src_sel != 3'd4) && (src_sel != 3'd5);
        end
        `OP_OUT: begin
          bus.new_val   = bus.out_data;
          bus.shift_osr = 1'b1;
          bus.wr_out_pins = (iw.gen.op1 == `DST_PINS);
          bus.wr_x        = (iw.gen.op1 == `DST_X);
          bus.wr_y        = (iw.gen.op1 == `DST_Y);
          bus.wr_out_dirs = (iw.gen.op1 == `DST_PINDIRS);
          bus.wr_pc       = (iw.gen.op1 == `DST_PC);
          bus.wr_isr      = (iw.gen.op1 == `DST_ISR);
        end
        `OP_PUSHPULL: begin
          if (!iw.gen.op1[2]) begin
            bus.wr_isr = 1'b1;                       // ISR clears even if nothing is sent
            push       = !full;
          end else begin
            bus.wr_osr  = 1'b1;
            pull        = !empty;
            bus.new_val = empty ? bus.x : din;       // Non-blocking empty takes X
          end
        end
        `OP_MOV: begin
          bus.new_val     = mov_val;
          bus.wr_out_pins = (iw.mov.dest == `DST_PINS);
          bus.wr_x        = (iw.mov.dest == `DST_X);
          bus.wr_y        = (iw.mov.dest == `DST_Y);
          bus.wr_pc       = (iw.mov.dest == `DST_PC);
          bus.wr_isr      = (iw.mov.dest == `DST_ISR);
          bus.wr_osr      = (iw.mov.dest == `DST_OSR);
        end
        `OP_SET: begin
          bus.new_val     = op2_ext;
          bus.wr_set_pins = (iw.gen.op1 == `DST_PINS);
          bus.wr_x        = (iw.gen.op1 == `DST_X);
          bus.wr_y        = (iw.gen.op1 == `DST_Y);
          bus.wr_set_dirs = (iw.gen.op1 == `DST_PINDIRS);
        end
        default: ;                                   // WAIT only advances
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      delay_cnt <= '0;
    end else if (en) begin
      if (delay_cnt != '0) delay_cnt <= delay_cnt - 1'b1;
      else if (fire) delay_cnt <= iw.gen.delay;      // Idle cycles after this one
    end
  end

  assign any_strobe = bus.wr_x | bus.wr_y | bus.dec_x | bus.dec_y | bus.wr_isr |
                      bus.shift_isr | bus.wr_osr | bus.shift_osr | bus.wr_pc |
                      bus.advance | bus.wr_out_pins | bus.wr_out_dirs |
                      bus.wr_set_pins | bus.wr_set_dirs;

  a_fifo_excl: assert property (@(posedge clk) disable iff (!rst_n) !(push && pull));

  // Bus stays quiet through every idle delay cycle
  a_delay_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    (delay_cnt != '0) |-> !any_strobe);

endmodule

// ==== sm_pc.sv ====
// Program counter with jump load and wrap from pend to wrap_target
`include "pio_consts.svh"

module sm_pc (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [4:0]             pend,
  input  logic [4:0]             wrap_target,
  sm_bus_if.pc                   bus,
  output logic [`PIO_ADDR_W-1:0] pc
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (bus.wr_pc) begin
      pc <= bus.new_val[`PIO_ADDR_W-1:0];          // Jump target
    end else if (bus.advance) begin
      pc <= (pc == pend) ? wrap_target : pc + 1'b1;
    end
  end

  a_pc_one_src: assert property (@(posedge clk) disable iff (!rst_n)
    !(bus.wr_pc && bus.advance));

endmodule

// ==== sm_scratch.sv ====
// X and Y scratch registers with load and decrement
`include "pio_consts.svh"

module sm_scratch (
  input  logic       clk,
  input  logic       rst_n,
  sm_bus_if.scratch  bus
);

  logic [`PIO_WORD_W-1:0] regs [2];                // 0 is X, 1 is Y
  logic [1:0]             wr, dec;

  assign wr  = {bus.wr_y, bus.wr_x};
  assign dec = {bus.dec_y, bus.dec_x};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (wr[i]) regs[i] <= bus.new_val;
        else if (dec[i]) regs[i] <= regs[i] - 1'b1;
      end
    end
  end

  assign bus.x = regs[0];
  assign bus.y = regs[1];

endmodule

// ==== sm_shift_in.sv ====
// Input shift register with saturating shift count
`include "pio_consts.svh"

module sm_shift_in (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_shift_dir,                // 1 shifts right, new bits at top
  sm_bus_if.shift_in  bus
);

  logic [`PIO_COUNT_W-1:0]  n;
  logic [`PIO_COUNT_W:0]    sum;
  logic [2*`PIO_WORD_W-1:0] left_cat, right_cat;

  assign n   = (bus.shift_n == '0) ? `PIO_COUNT_W'(`PIO_WORD_W) : {1'b0, bus.shift_n};
  assign sum = bus.isr_count + n;

  // Low n bits of new_val follow the old contents in the shift direction
  assign left_cat  = {bus.isr, bus.new_val << (`PIO_WORD_W - n)} << n;
  assign right_cat = {bus.new_val, bus.isr} >> n;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus.isr       <= '0;
      bus.isr_count <= '0;
    end else if (bus.wr_isr) begin
      bus.isr       <= bus.new_val;
      bus.isr_count <= '0;
    end else if (bus.shift_isr) begin
      bus.isr       <= in_shift_dir ? right_cat[`PIO_WORD_W-1:0]
                                    : left_cat[2*`PIO_WORD_W-1:`PIO_WORD_W];
      bus.isr_count <= (sum > `PIO_WORD_W) ? `PIO_COUNT_W'(`PIO_WORD_W)
                                           : sum[`PIO_COUNT_W-1:0];
    end
  end

endmodule

// ==== sm_shift_out.sv ====
// Output shift register with saturating shift count and out-data extraction
`include "pio_consts.svh"

module sm_shift_out (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         out_shift_dir,              // 1 shifts right, low bits leave
  sm_bus_if.shift_out  bus
);

  logic [`PIO_COUNT_W-1:0]  n;
  logic [`PIO_COUNT_W:0]    sum;
  logic [2*`PIO_WORD_W-1:0] shl, shr, mask_wide;

  assign n   = (bus.shift_n == '0) ? `PIO_COUNT_W'(`PIO_WORD_W) : {1'b0, bus.shift_n};
  assign sum = bus.osr_count + n;

  assign shl       = {{`PIO_WORD_W{1'b0}}, bus.osr} << n;  // Top word is the leaving bits
  assign shr       = {bus.osr, {`PIO_WORD_W{1'b0}}} >> n;
  assign mask_wide = ({{(2*`PIO_WORD_W-1){1'b0}}, 1'b1} << n) - 1'b1;

  assign bus.out_data = out_shift_dir ? (bus.osr & mask_wide[`PIO_WORD_W-1:0])
                                      : shl[2*`PIO_WORD_W-1:`PIO_WORD_W];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus.osr       <= '0;
      bus.osr_count <= `PIO_COUNT_W'(`PIO_WORD_W);  // Starts empty
    end else if (bus.wr_osr) begin
      bus.osr       <= bus.new_val;
      bus.osr_count <= '0;
    end else if (bus.shift_osr) begin
      bus.osr       <= out_shift_dir ? shr[2*`PIO_WORD_W-1:`PIO_WORD_W]
                                     : shl[`PIO_WORD_W-1:0];
      bus.osr_count <= (sum > `PIO_WORD_W) ? `PIO_COUNT_W'(`PIO_WORD_W)
                                           : sum[`PIO_COUNT_W-1:0];
    end
  end

endmodule

// ==== sm_pins.sv ====
// Output pin and pin-direction registers, written at a base over a count
`include "pio_consts.svh"

module sm_pins (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [4:0]             pins_out_base,
  input  logic [5:0]             pins_out_count,
  input  logic [4:0]             pins_set_base,
  input  logic [2:0]             pins_set_count,
  sm_bus_if.pins                 bus,
  output logic [`PIO_WORD_W-1:0] output_pins,
  output logic [`PIO_WORD_W-1:0] pin_directions
);

  logic                     set_sel;
  logic [4:0]               base;
  logic [5:0]               count;
  logic [2*`PIO_WORD_W-1:0] mask_wide, mask_rot, data_rot;
  logic [`PIO_WORD_W-1:0]   wmask, wdata;

  assign set_sel   = bus.wr_set_pins || bus.wr_set_dirs;
  assign base      = set_sel ? pins_set_base : pins_out_base;
  assign count     = set_sel ? {3'b000, pins_set_count} : pins_out_count;
  assign mask_wide = ({{(2*`PIO_WORD_W-1){1'b0}}, 1'b1} << count) - 1'b1;

  // Rotate left by base so writes wrap past pin 31
  assign mask_rot  = {mask_wide[`PIO_WORD_W-1:0], mask_wide[`PIO_WORD_W-1:0]} << base;
  assign data_rot  = {bus.new_val, bus.new_val} << base;
  assign wmask     = mask_rot[2*`PIO_WORD_W-1:`PIO_WORD_W];
  assign wdata     = data_rot[2*`PIO_WORD_W-1:`PIO_WORD_W];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      output_pins    <= '0;
      pin_directions <= '0;
    end else begin
      if (bus.wr_out_pins || bus.wr_set_pins)
        output_pins <= (output_pins & ~wmask) | (wdata & wmask);
      if (bus.wr_out_dirs || bus.wr_set_dirs)
        pin_directions <= (pin_directions & ~wmask) | (wdata & wmask);
    end
  end

  a_set_count: assert property (@(posedge clk) disable iff (!rst_n)
    set_sel |-> (pins_set_count <= 3'd5));

endmodule

// ==== pio_sm_top.sv ====
// State machine top level: execute unit and its register peers on one bus
`include "pio_consts.svh"

module pio_sm_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   en,               // Step strobe
  input  logic [15:0]            instr,
  input  logic [`PIO_WORD_W-1:0] input_pins,
  input  logic [`PIO_WORD_W-1:0] din,              // From TX FIFO
  input  logic                   empty,
  input  logic                   full,
  input  logic                   jmp_pin,
  input  logic [4:0]             pend,
  input  logic [4:0]             wrap_target,
  input  logic [4:0]             pins_out_base,
  input  logic [5:0]             pins_out_count,
  input  logic [4:0]             pins_set_base,
  input  logic [2:0]             pins_set_count,
  input  logic [4:0]             pins_in_base,
  input  logic                   out_shift_dir,    // 1 shifts right
  input  logic                   in_shift_dir,     // 1 shifts right
  input  logic [4:0]             osr_threshold,
  output logic [`PIO_ADDR_W-1:0] pc,
  output logic                   push,
  output logic                   pull,
  output logic [`PIO_WORD_W-1:0] dout,             // To RX FIFO
  output logic [`PIO_WORD_W-1:0] output_pins,
  output logic [`PIO_WORD_W-1:0] pin_directions
);

  sm_bus_if bus ();

  sm_exec u_exec (
    .clk           (clk),
    .rst_n         (rst_n),
    .en            (en),
    .instr         (instr),
    .input_pins    (input_pins),
    .empty         (empty),
    .full          (full),
    .jmp_pin       (jmp_pin),
    .pins_in_base  (pins_in_base),
    .osr_threshold (osr_threshold),
    .din           (din),
    .push          (push),
    .pull          (pull),
    .dout          (dout),
    .bus           (bus.exec)
  );

  sm_pc u_pc (
    .clk         (clk),
    .rst_n       (rst_n),
    .pend        (pend),
    .wrap_target (wrap_target),
    .bus         (bus.pc),
    .pc          (pc)
  );

  sm_scratch u_scratch (.clk(clk), .rst_n(rst_n), .bus(bus.scratch));

  sm_shift_in u_isr (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_shift_dir (in_shift_dir),
    .bus          (bus.shift_in)
  );

  sm_shift_out u_osr (
    .clk           (clk),
    .rst_n         (rst_n),
    .out_shift_dir (out_shift_dir),
    .bus           (bus.shift_out)
  );

  sm_pins u_pins (
    .clk            (clk),
    .rst_n          (rst_n),
    .pins_out_base  (pins_out_base),
    .pins_out_count (pins_out_count),
    .pins_set_base  (pins_set_base),
    .pins_set_count (pins_set_count),
    .bus            (bus.pins),
    .output_pins    (output_pins),
    .pin_directions (pin_directions)
  );

endmodule

// ==== tb_pio_sm.sv ====
// Self-checking testbench for the state machine top level
// Stimulus, configuration and expected outputs come from sm_golden.txt
module tb_pio_sm;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 3;
  localparam int SLACK_CYCLES = 20;
  localparam int MAX_LINES    = 256;

  logic        clk, rst_n, en, empty, full, jmp_pin;
  logic        out_shift_dir, in_shift_dir;
  logic [15:0] instr;
  logic [31:0] input_pins, din;
  logic [4:0]  pend, wrap_target, pins_out_base, pins_set_base, pins_in_base;
  logic [4:0]  osr_threshold;
  logic [5:0]  pins_out_count;
  logic [2:0]  pins_set_count;
  logic [4:0]  pc;
  logic        push, pull;
  logic [31:0] dout, output_pins, pin_directions;

  logic [31:0] fld [MAX_LINES][12];               // Parsed fields per file line
  byte         kind [MAX_LINES];                  // C or V
  logic [31:0] cfg [11];                          // Active configuration
  int          nlines, nvec, cycle_limit;
  bit          loaded;

  pio_sm_top pio_sm_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic load_golden(output string err);
    int          fd, cnt;
    bit          has_cfg;
    string       line;
    logic [31:0] v [12];
    err     = "";
    has_cfg = 1'b0;
    nlines  = 0;
    nvec    = 0;
    fd = $fopen("sm_golden.txt", "r");
    if (fd == 0) begin
      err = "Cannot open the golden data file sm_golden.txt";
      return;
    end
    while (!$feof(fd) && err == "") begin
      line = "";
      cnt  = $fgets(line, fd);
      if (line.len() == 0 || line[0] == "#" || line[0] == "\n") continue;
      if (line[0] == "C") begin
        cnt = $sscanf(line, "C %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
                      v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
        if (cnt != 11) err = $sformatf("Configuration line %0d is incomplete", nlines + 1);
        has_cfg = 1'b1;
      end else if (line[0] == "V") begin
        cnt = $sscanf(line, "V %h %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1], v[2],
                      v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11]);
        if (cnt != 12) err = $sformatf("Vector line %0d is incomplete", nlines + 1);
        if (!has_cfg) err = "The golden file does not start with a configuration line";
        nvec++;
      end else begin
        err = $sformatf("Line %0d of the golden file is not understood", nlines + 1);
      end
      if (nlines >= MAX_LINES) err = "The golden file has too many lines";
      else begin
        kind[nlines] = line[0];
        for (int k = 0; k < 12; k++) fld[nlines][k] = v[k];
        nlines++;
      end
    end
    $fclose(fd);
    if (err == "" && nvec == 0) err = "The golden file holds no vectors";
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Regression failed");
      $fatal(1, "Output mismatch");
    end
  endtask

  // Configuration ports are refreshed with every vector
  task automatic drive_inputs(input int i);
    jmp_pin        <= cfg[0][0];
    pend           <= cfg[1][4:0];
    wrap_target    <= cfg[2][4:0];
    pins_out_base  <= cfg[3][4:0];
    pins_out_count <= cfg[4][5:0];
    pins_set_base  <= cfg[5][4:0];
    pins_set_count <= cfg[6][2:0];
    pins_in_base   <= cfg[7][4:0];
    out_shift_dir  <= cfg[8][0];
    in_shift_dir   <= cfg[9][0];
    osr_threshold  <= cfg[10][4:0];
    en             <= fld[i][0][0];
    instr          <= fld[i][1][15:0];
    input_pins     <= fld[i][2];
    din            <= fld[i][3];
    empty          <= fld[i][4][0];
    full           <= fld[i][5][0];
  endtask

  task automatic check_outputs(input int i);
    compare_value("pc", 32'(pc), fld[i][6]);
    compare_value("push", 32'(push), fld[i][7]);
    compare_value("pull", 32'(pull), fld[i][8]);
    compare_value("dout", dout, fld[i][9]);
    compare_value("output_pins", output_pins, fld[i][10]);
    compare_value("pin_directions", pin_directions, fld[i][11]);
  endtask

  initial begin : stimulus
    string err;
    rst_n = 1'b0;
    {en, empty, full, jmp_pin, out_shift_dir, in_shift_dir} = '0;
    {instr, input_pins, din} = '0;
    {pend, wrap_target, pins_out_base, pins_set_base, pins_in_base} = '0;
    {osr_threshold, pins_out_count, pins_set_count} = '0;
    for (int k = 0; k < 11; k++) cfg[k] = '0;
    load_golden(err);
    if (err != "") begin
      $display("%s", err);
      $display("Regression failed");
      $fatal(1, "Golden data unusable");
    end else begin
      cycle_limit = nvec + RESET_CYCLES + SLACK_CYCLES;
      loaded      = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      for (int i = 0; i < nlines; i++) begin
        if (kind[i] == "C") begin
          for (int k = 0; k < 11; k++) cfg[k] = fld[i][k];
        end else begin
          @(posedge clk);
          drive_inputs(i);
          #(CLK_PERIOD - 1);                      // Just before the next edge
          check_outputs(i);
        end
      end
      $display("Regression passed");
      $finish;
    end
  end

  initial begin : watchdog
    int cycles;
    wait (loaded);
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the golden vectors did not finish within %0d cycles", cycle_limit);
    $display("Regression failed");
    $fatal(1, "Timeout");
  end

endmodule

// ==== sm_golden.txt ====
# C: jmp_pin pend wrap_target out_base out_count set_base set_count in_base out_dir in_dir osr_thr
# V: en instr input_pins din empty full, then expected pc push pull dout output_pins pin_dirs
C 0 10 06 04 04 1e 3 08 1 0 1f
V 0 e023 00000000 00000000 1 1 00 0 0 00000000 00000000 00000000
V 1 e023 00000000 00000000 1 1 00 0 0 00000000 00000000 00000000
V 1 0041 00000000 00000000 1 1 01 0 0 00000000 00000000 00000000
V 1 0041 00000000 00000000 1 1 01 0 0 00000000 00000000 00000000
V 0 0041 00000000 00000000 1 1 01 0 0 00000000 00000000 00000000
V 1 0041 00000000 00000000 1 1 01 0 0 00000000 00000000 00000000
V 1 0041 00000000 00000000 1 1 01 0 0 00000000 00000000 00000000
V 1 e085 00000000 00000000 1 1 02 0 0 00000000 00000000 00000000
V 1 80a0 00000000 00000000 1 1 03 0 0 00000000 00000000 40000001
V 1 80a0 00000000 12345678 0 1 03 0 1 00000000 00000000 40000001
V 1 6008 00000000 00000000 1 1 04 0 0 00000000 00000000 40000001
C 0 10 06 1c 08 1e 3 08 0 0 1f
V 1 6010 00000000 00000000 1 1 05 0 0 00000000 00000080 40000001
V 1 e033 00000000 00000000 1 1 06 0 0 00000000 20000081 40000001
V 1 a029 00000000 00000000 1 1 07 0 0 00000000 20000081 40000001
V 1 a009 00000000 00000000 1 1 08 0 0 00000000 20000081 40000001
V 1 a011 00000000 00000000 1 1 09 0 0 00000000 30000081 40000001
V 1 4020 00000000 00000000 1 1 0a 0 0 00000000 f000008f 40000001
V 1 8020 00000000 00000000 1 1 0b 0 0 00000000 f000008f 40000001
V 1 8020 00000000 00000000 1 0 0b 1 0 ffffffec f000008f 40000001
V 1 a043 00000000 00000000 1 1 0c 0 0 00000000 f000008f 40000001
V 1 006f 00000000 00000000 1 1 0d 0 0 00000000 f000008f 40000001
V 1 e202 00000000 00000000 1 1 0f 0 0 00000000 f000008f 40000001
V 1 20a2 00000000 00000000 1 1 10 0 0 00000000 b000008e 40000001
V 0 20a2 00000000 00000000 1 1 10 0 0 00000000 b000008e 40000001
V 1 20a2 00000000 00000000 1 1 10 0 0 00000000 b000008e 40000001
V 1 20a2 00000004 00000000 1 1 10 0 0 00000000 b000008e 40000001
V 1 20a2 00000400 00000000 1 1 10 0 0 00000000 b000008e 40000001
V 1 e033 00000000 00000000 1 1 06 0 0 00000000 b000008e 40000001

// ==== flist.f ====
+incdir+.
pio_pkg.sv
sm_bus_if.sv
sm_exec.sv
sm_pc.sv
sm_scratch.sv
sm_shift_in.sv
sm_shift_out.sv
sm_pins.sv
pio_sm_top.sv
tb_pio_sm.sv
